/* list.f */
+incdir+hdl
hdl/axi_wr_pkg.sv
hdl/axi_next_addr.sv
hdl/skid_buffer.sv
hdl/axi_wr_sub.sv
hdl/wr_reg_bank.sv
hdl/axi_wr_top.sv
verif/axi_wr_asserts.sv
verif/axi_wr_checker.sv
verif/axi_wr_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the AXI write testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module axi_wr_tb \
    -f list.f -o sim_axi_wr > build.log 2>&1 \
    && ./obj_dir/sim_axi_wr > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "\*\* FAIL \*\*" sim.log && { echo "Simulation reported failure"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

/* verif/axi_wr_stimulus.txt */
# W addr(hex) len size burst(0 FIXED 1 INCR 2 WRAP) id(hex) strb(0 full 1 random) bresp
# R word_index   reads the bank through the debug port and compares with the shadow
W 0000 3 2 1 1 0 0
R 0
R 3
W 0018 3 2 2 2 0 0
R 4
R 6
W 0024 1 2 2 3 0 0
W 0050 7 2 2 4 1 0
R 16
R 20
W 0060 5 2 0 5 0 0
R 24
W 0071 4 0 1 6 1 0
W 0082 2 1 1 7 0 0
R 28
R 32
W 00A0 15 2 1 8 0 0
W 00E0 3 2 1 9 0 0
R 40
R 55
W 00F8 3 2 1 a 0 2
R 62
R 63

/* verif/axi_wr_tb.sv */
//--------------------------------------------------------------------------
// Testbench top for the AXI write path
//   Clock, reset, stimulus file reader and AXI write driver
//   LCG for data and bready, cycle limit against a hung run
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "axi_wr_macros.svh"

module axi_wr_tb
    import axi_wr_pkg::*;
;

    localparam int MAX_CMDS = 64;

    logic       clk;
    logic       rst_n;
    logic       i_awvalid, o_awready;
    axi_addr_t  i_awaddr;
    axi_len_t   i_awlen;
    axi_size_t  i_awsize;
    logic [1:0] i_awburst;
    axi_id_t    i_awid;
    logic       i_wvalid, o_wready, i_wlast;
    axi_data_t  i_wdata;
    axi_strb_t  i_wstrb;
    logic       o_bvalid, i_bready;
    logic [1:0] o_bresp;
    axi_id_t    o_bid;
    logic [$clog2(`BANK_WORDS)-1:0] i_dbg_addr;
    axi_data_t  o_dbg_data;
    logic [1:0] exp_resp;
    logic       rd_req;
    int         tests, errors, pending;

    // Parsed stimulus, one entry per command line
    byte        c_kind [MAX_CMDS];
    int         c_addr [MAX_CMDS];
    int         c_len [MAX_CMDS];
    int         c_size [MAX_CMDS];
    int         c_burst [MAX_CMDS];
    int         c_id [MAX_CMDS];
    int         c_smode [MAX_CMDS];
    int         c_resp [MAX_CMDS];
    int         n_cmds;
    int         cycles;
    int         cycle_limit = 1000000;
    int         aw_sent;
    int         b_done;
    logic [31:0] data_seed;
    logic [31:0] rdy_seed;

    axi_wr_top i_dut (
        .clk(clk), .rst_n(rst_n),
        .i_awvalid(i_awvalid), .o_awready(o_awready), .i_awaddr(i_awaddr),
        .i_awlen(i_awlen), .i_awsize(i_awsize), .i_awburst(i_awburst), .i_awid(i_awid),
        .i_wvalid(i_wvalid), .o_wready(o_wready), .i_wdata(i_wdata),
        .i_wstrb(i_wstrb), .i_wlast(i_wlast),
        .o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp), .o_bid(o_bid),
        .i_dbg_addr(i_dbg_addr), .o_dbg_data(o_dbg_data)
    );

    axi_wr_checker i_chk (
        .clk(clk), .rst_n(rst_n),
        .i_awvalid(i_awvalid), .i_awready(o_awready), .i_awaddr(i_awaddr),
        .i_awlen(i_awlen), .i_awsize(i_awsize), .i_awburst(i_awburst), .i_awid(i_awid),
        .i_wvalid(i_wvalid), .i_wready(o_wready), .i_wdata(i_wdata), .i_wstrb(i_wstrb),
        .i_bvalid(o_bvalid), .i_bready(i_bready), .i_bresp(o_bresp), .i_bid(o_bid),
        .i_exp_resp(exp_resp), .i_rd_req(rd_req), .i_rd_idx(i_dbg_addr),
        .i_dbg_data(o_dbg_data),
        .o_tests(tests), .o_errors(errors), .o_pending(pending)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Byte address of beat n of a burst, closed form
    function automatic int beat_addr(input int start, input int n, input int sz,
                                     input int bt, input int ln);
        int bytes;
        int win;
        int base;
        bytes = 1 << sz;
        win   = bytes * (ln + 1);
        base  = start - (start % win);
        if (bt == 0) begin
            return start;
        end else if (bt == 1) begin
            return (n == 0) ? start : (start - (start % bytes)) + n * bytes;
        end
        return base + ((start - base + n * bytes) % win);
    endfunction

    task automatic read_stimulus();
        int    fd;
        int    r;
        string line;
        n_cmds = 0;
        fd = $fopen("verif/axi_wr_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            return;
        end
        while (!$feof(fd) && n_cmds < MAX_CMDS) begin
            r = $fgets(line, fd);
            if (r > 1 && line[0] == "W") begin
                r = $sscanf(line.substr(2, line.len() - 1), "%h %d %d %d %h %d %d",
                            c_addr[n_cmds], c_len[n_cmds], c_size[n_cmds],
                            c_burst[n_cmds], c_id[n_cmds], c_smode[n_cmds], c_resp[n_cmds]);
                c_kind[n_cmds] = "W";
                n_cmds++;
            end else if (r > 1 && line[0] == "R") begin
                r = $sscanf(line.substr(2, line.len() - 1), "%d", c_addr[n_cmds]);
                c_kind[n_cmds] = "R";
                n_cmds++;
            end
        end
        $fclose(fd);
    endtask

    // One AW, then every W beat, each waiting for its ready
    task automatic run_burst(input int k);
        int        a;
        int        bytes;
        axi_strb_t m;
        @(posedge clk);
        #1;
        i_awaddr  = axi_addr_t'(c_addr[k]);
        i_awlen   = axi_len_t'(c_len[k]);
        i_awsize  = axi_size_t'(c_size[k]);
        i_awburst = 2'(c_burst[k]);
        i_awid    = axi_id_t'(c_id[k]);
        exp_resp  = 2'(c_resp[k]);
        i_awvalid = 1'b1;
        do @(negedge clk); while (!o_awready);
        @(posedge clk);
        #1;
        i_awvalid = 1'b0;
        aw_sent++;
        for (int n = 0; n <= c_len[k]; n++) begin
            a     = beat_addr(c_addr[k], n, c_size[k], c_burst[k], c_len[k]);
            bytes = 1 << c_size[k];
            // Byte lanes of this beat
            m     = axi_strb_t'(((1 << bytes) - 1) << ((a % 4) - ((a % 4) % bytes)));
            data_seed = lcg_next(data_seed);
            i_wdata   = data_seed;
            if (c_smode[k] != 0) begin
                m = m & data_seed[19:16];
            end
            i_wstrb  = m;
            i_wlast  = (n == c_len[k]);
            i_wvalid = 1'b1;
            do @(negedge clk); while (!o_wready);
            @(posedge clk);
            #1;
        end
        i_wvalid = 1'b0;
        i_wlast  = 1'b0;
    endtask

    // Responses are counted at the falling edge, so look at the rising one
    task automatic wait_responses();
        do @(posedge clk); while (b_done != aw_sent);
    endtask

    // One debug read, compared by the checker at the next falling edge
    task automatic read_word(input int idx);
        @(posedge clk);
        #1;
        i_dbg_addr = 6'(idx);
        rd_req     = 1'b1;
        @(posedge clk);
        #1;
        rd_req = 1'b0;
    endtask

    task automatic readback(input int k);
        wait_responses();
        read_word(c_addr[k]);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Random B back-pressure
    initial begin
        rdy_seed = 32'd80;
        i_bready = 1'b0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #1;
            rdy_seed = lcg_next(rdy_seed);
            i_bready = rdy_seed[16];
        end
    end

    always @(negedge clk) begin
        if (rst_n && o_bvalid && i_bready) begin
            b_done++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        rst_n      = 1'b0;
        i_awvalid  = 1'b0;
        i_awaddr   = '0;
        i_awlen    = '0;
        i_awsize   = '0;
        i_awburst  = '0;
        i_awid     = '0;
        i_wvalid   = 1'b0;
        i_wdata    = '0;
        i_wstrb    = '0;
        i_wlast    = 1'b0;
        i_dbg_addr = '0;
        exp_resp   = '0;
        rd_req     = 1'b0;
        cycles     = 0;
        aw_sent    = 0;
        b_done     = 0;
        data_seed  = 32'd80;
        read_stimulus();
        cycle_limit = 64 * n_cmds + 200;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int k = 0; k < n_cmds; k++) begin
            if (c_kind[k] == "W") begin
                run_burst(k);
            end else begin
                readback(k);
            end
        end
        wait_responses();
        // Whole bank against the shadow, out-of-range beats must not alias low words
        for (int w = 0; w < `BANK_WORDS; w++) begin
            read_word(w);
        end
        repeat (4) @(posedge clk);
        $display("Tests: %0d, errors: %0d, missing responses: %0d", tests, errors, pending);
        if (errors == 0 && pending == 0 && n_cmds > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verif/axi_wr_checker.sv */
//--------------------------------------------------------------------------
// Testbench checker for the AXI write path
//   Follows AW and W transfers into a shadow memory
//   Compares B responses with expected values and debug reads with shadow
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module axi_wr_checker
    import axi_wr_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_awvalid,
    input  logic       i_awready,
    input  axi_addr_t  i_awaddr,
    input  axi_len_t   i_awlen,
    input  axi_size_t  i_awsize,
    input  logic [1:0] i_awburst,
    input  axi_id_t    i_awid,
    input  logic       i_wvalid,
    input  logic       i_wready,
    input  axi_data_t  i_wdata,
    input  axi_strb_t  i_wstrb,
    input  logic       i_bvalid,
    input  logic       i_bready,
    input  logic [1:0] i_bresp,
    input  axi_id_t    i_bid,
    input  logic [1:0] i_exp_resp,
    input  logic       i_rd_req,
    input  logic [5:0] i_rd_idx,
    input  axi_data_t  i_dbg_data,
    output int         o_tests,
    output int         o_errors,
    output int         o_pending
);

    axi_data_t  shadow [64];
    // Open bursts, oldest first
    axi_addr_t  bq_addr [$];
    axi_len_t   bq_len [$];
    axi_size_t  bq_size [$];
    logic [1:0] bq_burst [$];
    // Expected responses in request order
    axi_id_t    eq_id [$];
    logic [1:0] eq_resp [$];
    int         beat_n;
    axi_addr_t  cur_addr;

    // Address of the beat after a, worked out arithmetically
    function automatic axi_addr_t step_addr(input axi_addr_t a, input axi_size_t sz,
                                            input logic [1:0] bt, input axi_len_t ln);
        int bytes;
        int win;
        int base;
        bytes = 1 << sz;
        win   = bytes * (ln + 1);
        base  = (a / win) * win;
        if (bt == 2'd0) begin
            return a;
        end else if (bt == 2'd1) begin
            return axi_addr_t'((a / bytes) * bytes + bytes);
        end
        return axi_addr_t'(base + ((a - base + bytes) % win));
    endfunction

    initial begin
        for (int i = 0; i < 64; i++) begin
            shadow[i] = '0;
        end
        beat_n    = 0;
        o_tests   = 0;
        o_errors  = 0;
        o_pending = 0;
    end

    // Sampled at the falling edge, between driver updates and the transfer edge
    always @(negedge clk) begin : watch
        axi_addr_t a;
        int        word;
        if (rst_n) begin
            if (i_awvalid && i_awready) begin
                bq_addr.push_back(i_awaddr);
                bq_len.push_back(i_awlen);
                bq_size.push_back(i_awsize);
                bq_burst.push_back(i_awburst);
                eq_id.push_back(i_awid);
                eq_resp.push_back(i_exp_resp);
            end
            if (i_wvalid && i_wready) begin
                if (bq_addr.size() == 0) begin
                    $display("W beat accepted with no open burst at %0t ns", $time);
                    o_errors++;
                end else begin
                    a    = (beat_n == 0) ? bq_addr[0] : cur_addr;
                    word = a >> 2;
                    // Beats past the bank end leave the shadow alone
                    if (word < 64) begin
                        for (int b = 0; b < 4; b++) begin
                            if (i_wstrb[b]) begin
                                shadow[word][b*8 +: 8] = i_wdata[b*8 +: 8];
                            end
                        end
                    end
                    cur_addr = step_addr(a, bq_size[0], bq_burst[0], bq_len[0]);
                    beat_n++;
                    if (beat_n > bq_len[0]) begin
                        beat_n = 0;
                        void'(bq_addr.pop_front());
                        void'(bq_len.pop_front());
                        void'(bq_size.pop_front());
                        void'(bq_burst.pop_front());
                    end
                end
            end
            if (i_bvalid && i_bready) begin
                o_tests++;
                if (eq_id.size() == 0) begin
                    $display("B response arrived with no outstanding request at %0t ns",
                             $time);
                    o_errors++;
                end else begin
                    if (i_bid !== eq_id[0] || i_bresp !== eq_resp[0]) begin
                        $display("Error at %0t ns: B id %0h resp %0d, expected id %0h resp %0d",
                                 $time, i_bid, i_bresp, eq_id[0], eq_resp[0]);
                        o_errors++;
                    end else begin
                        $display("Test %0d: burst id %0h response %0d ok", o_tests, i_bid,
                                 i_bresp);
                    end
                    void'(eq_id.pop_front());
                    void'(eq_resp.pop_front());
                end
            end
            if (i_rd_req) begin
                o_tests++;
                if (i_dbg_data !== shadow[i_rd_idx]) begin
                    $display("Error at %0t ns: word %0d reads %h, expected %h", $time,
                             i_rd_idx, i_dbg_data, shadow[i_rd_idx]);
                    o_errors++;
                end else begin
                    $display("Test %0d: word %0d reads %h ok", o_tests, i_rd_idx, i_dbg_data);
                end
            end
            o_pending = eq_id.size();
        end
    end

endmodule

/* verif/axi_wr_asserts.sv */
//--------------------------------------------------------------------------
// Concurrent AXI handshake assertions for the write path top level
//   Valids hold until ready on AW, W and B, B payload stable while stalled
//   bvalid low during reset
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module axi_wr_asserts (
    input logic       clk,
    input logic       rst_n,
    input logic       i_awvalid,
    input logic       o_awready,
    input logic       i_wvalid,
    input logic       o_wready,
    input logic       o_bvalid,
    input logic       i_bready,
    input logic [1:0] o_bresp,
    input logic [3:0] o_bid
);

    // A raised valid stays up until its transfer
    property valid_held(v, r);
        @(posedge clk) disable iff (!rst_n) (v && !r) |=> v;
    endproperty

    a_aw_hold: assert property (valid_held(i_awvalid, o_awready))
        else $error("AW valid dropped before ready");
    a_w_hold: assert property (valid_held(i_wvalid, o_wready))
        else $error("W valid dropped before ready");
    a_b_hold: assert property (valid_held(o_bvalid, i_bready))
        else $error("B valid dropped before ready");

    a_b_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (o_bvalid && !i_bready) |=> $stable({o_bresp, o_bid}))
        else $error("B payload changed while stalled");

    a_b_reset: assert property (@(posedge clk) !rst_n |-> !o_bvalid)
        else $error("B valid high during reset");

endmodule

bind axi_wr_top axi_wr_asserts i_asserts (
    .clk(clk), .rst_n(rst_n),
    .i_awvalid(i_awvalid), .o_awready(o_awready),
    .i_wvalid(i_wvalid), .o_wready(o_wready),
    .o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp), .o_bid(o_bid)
);

/* hdl/axi_wr_top.sv */
//--------------------------------------------------------------------------
// Top level of the AXI write path
//   Write subordinate feeding the register bank, debug read port exposed
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "axi_wr_macros.svh"

module axi_wr_top
    import axi_wr_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_awvalid,
    output logic                          o_awready,
    input  axi_addr_t                     i_awaddr,
    input  axi_len_t                      i_awlen,
    input  axi_size_t                     i_awsize,
    input  logic [1:0]                    i_awburst,
    input  axi_id_t                       i_awid,
    input  logic                          i_wvalid,
    output logic                          o_wready,
    input  axi_data_t                     i_wdata,
    input  axi_strb_t                     i_wstrb,
    input  logic                          i_wlast,
    output logic                          o_bvalid,
    input  logic                          i_bready,
    output logic [1:0]                    o_bresp,
    output axi_id_t                       o_bid,
    input  logic [$clog2(`BANK_WORDS)-1:0] i_dbg_addr,
    output axi_data_t                     o_dbg_data
);

    // Component interface between subordinate and bank
    logic      c_dv;
    axi_addr_t c_addr;
    axi_data_t c_wdata;
    axi_strb_t c_wstrb;
    logic      c_hld;
    logic      c_err;

    axi_wr_sub i_sub (
        .clk(clk), .rst_n(rst_n),
        .i_awvalid(i_awvalid), .o_awready(o_awready), .i_awaddr(i_awaddr),
        .i_awlen(i_awlen), .i_awsize(i_awsize), .i_awburst(i_awburst), .i_awid(i_awid),
        .i_wvalid(i_wvalid), .o_wready(o_wready), .i_wdata(i_wdata),
        .i_wstrb(i_wstrb), .i_wlast(i_wlast),
        .o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp), .o_bid(o_bid),
        .o_dv(c_dv), .o_addr(c_addr), .o_wdata(c_wdata), .o_wstrb(c_wstrb),
        .i_hld(c_hld), .i_err(c_err)
    );

    wr_reg_bank i_bank (
        .clk(clk), .rst_n(rst_n),
        .i_dv(c_dv), .i_addr(c_addr), .i_wdata(c_wdata), .i_wstrb(c_wstrb),
        .o_hld(c_hld), .o_err(c_err),
        .i_dbg_addr(i_dbg_addr), .o_dbg_data(o_dbg_data)
    );

endmodule

/* hdl/wr_reg_bank.sv */
//--------------------------------------------------------------------------
// Register bank behind the component write interface
//   Byte-strobed word writes, one wait cycle in the slow region
//   err on beats past the bank end, combinational debug read port
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "axi_wr_macros.svh"

module wr_reg_bank
    import axi_wr_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_dv,
    input  axi_addr_t                     i_addr,
    input  axi_data_t                     i_wdata,
    input  axi_strb_t                     i_wstrb,
    output logic                          o_hld,
    output logic                          o_err,
    input  logic [$clog2(`BANK_WORDS)-1:0] i_dbg_addr,
    output axi_data_t                     o_dbg_data
);

    localparam int BC = `AXI_DW / 8;
    localparam int BW = $clog2(BC);
    localparam int XW = $clog2(`BANK_WORDS);

    axi_data_t              mem [`BANK_WORDS];
    logic [`AXI_AW-BW-1:0]  word_idx;
    logic                   in_range;
    logic                   slow;
    logic                   wait_done;
    logic                   wr_en;

    // Word index from the byte address
    assign word_idx = i_addr[`AXI_AW-1:BW];
    assign in_range = (word_idx < (`AXI_AW-BW)'(`BANK_WORDS));
    assign slow     = in_range && (word_idx >= (`AXI_AW-BW)'(`BANK_SLOW_BASE));

    // Slow beat holds in its first cycle only
    assign o_hld = i_dv && slow && !wait_done;
    assign o_err = i_dv && !in_range;
    assign wr_en = i_dv && !o_hld && in_range;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_done <= 1'b0;
        end else begin
            wait_done <= o_hld;
        end
    end

    // Only strobed bytes change
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `BANK_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            for (int b = 0; b < BC; b++) begin
                if (i_wstrb[b]) begin
                    mem[word_idx[XW-1:0]][b*8 +: 8] <= i_wdata[b*8 +: 8];
                end
            end
        end
    end

    assign o_dbg_data = mem[i_dbg_addr];

endmodule

/* hdl/axi_wr_sub.sv */
//--------------------------------------------------------------------------
// AXI write subordinate
//   Skid buffers on AW, W and B, one burst context with its own FSM
//   Splits bursts into single-beat component writes with dv/hld/err
//   Responses leave in request order, SLVERR if any beat saw err
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module axi_wr_sub
    import axi_wr_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // AW channel
    input  logic      i_awvalid,
    output logic      o_awready,
    input  axi_addr_t i_awaddr,
    input  axi_len_t  i_awlen,
    input  axi_size_t i_awsize,
    input  logic [1:0] i_awburst,
    input  axi_id_t   i_awid,
    // W channel
    input  logic      i_wvalid,
    output logic      o_wready,
    input  axi_data_t i_wdata,
    input  axi_strb_t i_wstrb,
    input  logic      i_wlast,
    // B channel
    output logic      o_bvalid,
    input  logic      i_bready,
    output logic [1:0] o_bresp,
    output axi_id_t   o_bid,
    // Component side
    output logic      o_dv,
    output axi_addr_t o_addr,
    output axi_data_t o_wdata,
    output axi_strb_t o_wstrb,
    input  logic      i_hld,
    input  logic      i_err
);

    localparam int ABITS = $bits(axi_addr_t);
    localparam int BW    = $clog2($bits(axi_strb_t));
    localparam int AWD   = ABITS + $bits(axi_len_t) + $bits(axi_size_t) + 2 + $bits(axi_id_t);
    localparam int WD    = $bits(axi_data_t) + $bits(axi_strb_t) + 1;
    localparam int BD    = $bits(axi_resp_e) + $bits(axi_id_t);

    sub_state_e state, state_nxt;
    logic       req_valid, req_ready;
    axi_addr_t  req_addr;
    axi_len_t   req_len;
    axi_size_t  req_size;
    logic [1:0] req_burst;
    axi_id_t    req_id;
    // Burst context
    axi_addr_t  txn_addr, txn_addr_nxt;
    axi_size_t  txn_size;
    axi_burst_e txn_burst;
    axi_len_t   txn_len;
    axi_id_t    txn_id;
    logic       txn_err;
    logic       in_burst, w_in_valid, w_in_ready, w_valid, w_last;
    logic       beat_done, last_done;
    logic       rp_valid, rp_ready;
    axi_resp_e  rp_resp;

    //--------------------------------------------------------------------------
    // Request path
    //--------------------------------------------------------------------------
    skid_buffer #(.DW(AWD), .OPT_OUTREG(1'b0)) i_aw_skd (
        .clk(clk), .rst_n(rst_n),
        .i_valid(i_awvalid), .o_ready(o_awready),
        .i_data({i_awaddr, i_awlen, i_awsize, i_awburst, i_awid}),
        .o_valid(req_valid), .i_ready(req_ready),
        .o_data({req_addr, req_len, req_size, req_burst, req_id})
    );

    // New burst only when idle and a B slot is guaranteed
    assign req_ready = (state == SUB_IDLE) && rp_ready;
    assign in_burst  = (state == SUB_BURST);
    assign beat_done = o_dv && !i_hld;
    assign last_done = beat_done && w_last;

    // B slot reserved at acceptance, so the last beat always finds room
    always_comb begin
        state_nxt = state;
        case (state)
            SUB_IDLE:  if (req_valid && req_ready) state_nxt = SUB_BURST;
            SUB_BURST: if (last_done) state_nxt = SUB_IDLE;
            default:   state_nxt = SUB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= SUB_IDLE;
            txn_err <= 1'b0;
        end else begin
            state <= state_nxt;
            if (req_valid && req_ready) begin
                txn_err <= 1'b0;
            end else if (beat_done) begin
                txn_err <= txn_err || i_err;
            end
        end
    end

    // Context loads on acceptance, address steps on every completed beat
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            txn_addr  <= req_addr;
            txn_size  <= req_size;
            txn_burst <= axi_burst_e'(req_burst);
            txn_len   <= req_len;
            txn_id    <= req_id;
        end else if (beat_done) begin
            txn_addr  <= txn_addr_nxt;
        end
    end

    axi_next_addr i_next_addr (
        .i_addr(txn_addr), .i_size(txn_size), .i_burst(txn_burst),
        .i_len(txn_len), .o_next_addr(txn_addr_nxt)
    );

    //--------------------------------------------------------------------------
    // Data path
    //--------------------------------------------------------------------------
    // W accepted only while a burst is active
    assign w_in_valid = i_wvalid && in_burst;
    assign o_wready   = w_in_ready && in_burst;

    skid_buffer #(.DW(WD), .OPT_OUTREG(1'b0)) i_w_skd (
        .clk(clk), .rst_n(rst_n),
        .i_valid(w_in_valid), .o_ready(w_in_ready),
        .i_data({i_wdata, i_wstrb, i_wlast}),
        .o_valid(w_valid), .i_ready(in_burst && !i_hld),
        .o_data({o_wdata, o_wstrb, w_last})
    );

    // Beats of a following burst wait in the buffer until their AW is taken
    assign o_dv   = w_valid && in_burst;
    assign o_addr = {txn_addr[ABITS-1:BW], BW'(0)};

    //--------------------------------------------------------------------------
    // Response path
    //--------------------------------------------------------------------------
    assign rp_valid = last_done;
    assign rp_resp  = (txn_err || (beat_done && i_err)) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;

    skid_buffer #(.DW(BD), .OPT_OUTREG(1'b1)) i_b_skd (
        .clk(clk), .rst_n(rst_n),
        .i_valid(rp_valid), .o_ready(rp_ready),
        .i_data({rp_resp, txn_id}),
        .o_valid(o_bvalid), .i_ready(i_bready),
        .o_data({o_bresp, o_bid})
    );

endmodule

/* hdl/skid_buffer.sv */
//--------------------------------------------------------------------------
// Valid/ready skid buffer with one spare entry
//   Upstream ready is registered, so a falling downstream ready loses nothing
//   OPT_OUTREG selects a registered output stage over pass-through
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module skid_buffer #(
    parameter int DW         = 8,
    parameter bit OPT_OUTREG = 1'b0
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          i_valid,
    output logic          o_ready,
    input  logic [DW-1:0] i_data,
    output logic          o_valid,
    input  logic          i_ready,
    output logic [DW-1:0] o_data
);

    logic          skid_valid;
    logic [DW-1:0] skid_data;

    // Upstream sees ready while the spare entry is free
    assign o_ready = !skid_valid;

    // Capture into the spare entry when the output stalls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            skid_valid <= 1'b0;
        end else if (i_valid && o_ready && o_valid && !i_ready) begin
            skid_valid <= 1'b1;
        end else if (i_ready) begin
            skid_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (o_ready) begin
            skid_data <= i_data;
        end
    end

    generate
        if (OPT_OUTREG) begin : g_outreg
            logic          out_valid;
            logic [DW-1:0] out_data;

            // Output register loads whenever it is empty or being drained
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    out_valid <= 1'b0;
                end else if (!out_valid || i_ready) begin
                    out_valid <= i_valid || skid_valid;
                end
            end

            // Spare entry is older, so it goes first
            always_ff @(posedge clk) begin
                if (!out_valid || i_ready) begin
                    out_data <= skid_valid ? skid_data : i_data;
                end
            end

            assign o_valid = out_valid;
            assign o_data  = out_data;
        end else begin : g_pass
            // Input straight through unless an entry is held
            assign o_valid = i_valid || skid_valid;
            assign o_data  = skid_valid ? skid_data : i_data;
        end
    endgenerate

endmodule

/* hdl/axi_next_addr.sv */
//--------------------------------------------------------------------------
// Next beat address of an AXI burst
//   FIXED keeps the address, INCR steps by the beat size
//   WRAP steps inside a window of size times beat count bytes
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module axi_next_addr
    import axi_wr_pkg::*;
(
    input  axi_addr_t  i_addr,
    input  axi_size_t  i_size,
    input  axi_burst_e i_burst,
    input  axi_len_t   i_len,
    output axi_addr_t  o_next_addr
);

    axi_addr_t beat_bytes;
    axi_addr_t addr_algn;
    axi_addr_t addr_incr;
    axi_addr_t wrap_mask;

    always_comb begin
        beat_bytes = axi_addr_t'(1) << i_size;
        // Unaligned first beat of INCR lands on the next size boundary
        addr_algn  = i_addr & ~(beat_bytes - axi_addr_t'(1));
        addr_incr  = addr_algn + beat_bytes;
        // Window is a power of two for legal wrap lengths (2, 4, 8, 16)
        wrap_mask  = beat_bytes * (axi_addr_t'(i_len) + axi_addr_t'(1)) - axi_addr_t'(1);
        case (i_burst)
            AXI_BURST_FIXED: o_next_addr = i_addr;
            AXI_BURST_INCR:  o_next_addr = addr_incr;
            AXI_BURST_WRAP:  o_next_addr = (i_addr & ~wrap_mask) | (addr_incr & wrap_mask);
            default:         o_next_addr = i_addr;
        endcase
    end

endmodule

/* hdl/axi_wr_pkg.sv */
//--------------------------------------------------------------------------
// Shared types of the AXI write path
//   Width typedefs, burst and response encodings, subordinate FSM states
//--------------------------------------------------------------------------
`include "axi_wr_macros.svh"

package axi_wr_pkg;

    typedef logic [`AXI_AW-1:0]   axi_addr_t;
    typedef logic [`AXI_DW-1:0]   axi_data_t;
    typedef logic [`AXI_DW/8-1:0] axi_strb_t;
    typedef logic [`AXI_IW-1:0]   axi_id_t;
    typedef logic [7:0]           axi_len_t;
    typedef logic [2:0]           axi_size_t;

    // AxBURST and xRESP encodings as on the bus
    typedef enum logic [1:0] {AXI_BURST_FIXED = 2'b00, AXI_BURST_INCR = 2'b01,
                              AXI_BURST_WRAP = 2'b10} axi_burst_e;
    typedef enum logic [1:0] {AXI_RESP_OKAY = 2'b00, AXI_RESP_EXOKAY = 2'b01,
                              AXI_RESP_SLVERR = 2'b10} axi_resp_e;

    typedef enum logic [1:0] {SUB_IDLE, SUB_BURST, SUB_RESP} sub_state_e;

endpackage

/* hdl/axi_wr_macros.svh */
//--------------------------------------------------------------------------
// Width and size macros shared by the AXI write subordinate and the bank
//   Address, data and ID widths of the AXI side
//   Bank depth and the start of its slow region
//--------------------------------------------------------------------------
`ifndef AXI_WR_MACROS_SVH
`define AXI_WR_MACROS_SVH

`define AXI_AW 16
`define AXI_DW 32
`define AXI_IW 4

// Bank depth in 32-bit words, slow region from this word index upward
`define BANK_WORDS     64
`define BANK_SLOW_BASE 32
`endif
